// ==== source/align_pkg.sv ====
package align_pkg;

  //////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////

  // Bus word, also a full 32-bit instruction
  typedef logic [31:0] word_t;

  // One halfword, the unit of compressed instructions
  typedef logic [15:0] half_t;

  // Byte address of an instruction
  typedef logic [31:0] addr_t;

  //////////////////////////////////////////////////
  // Buffer sizing
  //////////////////////////////////////////////////

  // Three words cover two fetches in flight plus a split instruction
  localparam int unsigned FIFO_DEPTH = 3;

  // Index into the word store
  typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

  // Limit on fetches in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Outstanding and flush counters
  typedef logic [1:0] cnt_t;

  // Complete instructions held, up to two per word
  typedef logic [2:0] icnt_t;

  // Where the next incoming word starts relative to instruction boundaries
  typedef enum logic [1:0] {
    PHASE_ALIGNED,
    PHASE_SKIP_LOW,
    PHASE_SPLIT
  } word_phase_e;

endpackage

// ==== source/word_window_if.sv ====
`timescale 1ns/1ns

interface word_window_if import align_pkg::*; ();

  // Word at the read pointer, or the incoming response
  word_t head_word;
  logic  head_err;
  logic  head_valid;

  // Word after the read pointer, or the incoming response
  word_t next_word;
  logic  next_err;
  logic  next_valid;

  // Head word fully used, step the read pointer
  logic  advance;

  modport fifo_mp (
    output head_word, head_err, head_valid,
    output next_word, next_err, next_valid,
    input  advance
  );

  modport aligner_mp (
    input  head_word, head_err, head_valid,
    input  next_word, next_err, next_valid,
    output advance
  );

endinterface

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  instr_req_i,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  addr_t branch_addr_i,
  input  logic  fetch_ready_i,
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  emit_i,
  output logic  fetch_valid_o,
  output logic  busy_o,
  output logic  resp_accept_o
);

  cnt_t        outst_q, outst_n;
  cnt_t        flush_q, flush_n, flush_branch;
  icnt_t       icnt_q, icnt_n, icnt_adj;
  word_phase_e phase_q, phase_n;
  cnt_t        n_incoming;
  logic        pop_q;
  logic        fetch_acc;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // Responses still owed to an old fetch stream are dropped
  assign resp_accept_o = (flush_q != '0) ? 1'b0 : resp_valid_i;

  // Count seen by the request logic, last pop applied late
  assign icnt_adj = icnt_q - icnt_t'(pop_q);

  assign fetch_valid_o = instr_req_i &&
                         (outst_q < cnt_t'(MAX_OUTSTANDING)) &&
                         ((icnt_adj == icnt_t'(0)) ||
                          ((icnt_adj == icnt_t'(1)) && (outst_q == '0)) ||
                          pc_set_i);

  // Busy while responses are due or a request is up
  assign busy_o    = (outst_q != '0) || fetch_valid_o;
  assign fetch_acc = fetch_valid_o && fetch_ready_i;

  // Up on an accepted fetch, down on every raw response
  always_comb begin
    outst_n = outst_q;
    if (fetch_acc && !resp_valid_i) begin
      outst_n = outst_q + cnt_t'(1);
    end else if (!fetch_acc && resp_valid_i) begin
      outst_n = outst_q - cnt_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Flush and instruction counting
  //////////////////////////////////////////////////

  // A response arriving with the kill is already out of the way
  always_comb begin
    flush_branch = outst_q;
    if (kill_i && resp_valid_i) begin
      flush_branch = outst_q - cnt_t'(1);
    end
  end

  always_comb begin
    flush_n = flush_q;
    if (pc_set_i) begin
      flush_n = flush_branch;
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - cnt_t'(1);
    end
  end

  // Complete instructions in each accepted word
  always_comb begin
    phase_n    = phase_q;
    n_incoming = '0;
    if (pc_set_i) begin
      // Unaligned target, low half of the first word is skipped
      phase_n = branch_addr_i[1] ? PHASE_SKIP_LOW : PHASE_ALIGNED;
    end else if (resp_accept_o) begin
      unique case (phase_q)
        PHASE_ALIGNED: begin
          if (resp_rdata_i[1:0] == 2'b11) begin
            n_incoming = cnt_t'(1);
          end else if (resp_rdata_i[17:16] == 2'b11) begin
            // Upper half opens a 32-bit instruction
            n_incoming = cnt_t'(1);
            phase_n    = PHASE_SPLIT;
          end else begin
            n_incoming = cnt_t'(2);
          end
        end
        PHASE_SKIP_LOW: begin
          if (resp_rdata_i[17:16] == 2'b11) begin
            phase_n = PHASE_SPLIT;
          end else begin
            n_incoming = cnt_t'(1);
            phase_n    = PHASE_ALIGNED;
          end
        end
        default: begin
          // Low half closes the split instruction
          if (resp_rdata_i[17:16] == 2'b11) begin
            n_incoming = cnt_t'(1);
          end else begin
            n_incoming = cnt_t'(2);
            phase_n    = PHASE_ALIGNED;
          end
        end
      endcase
    end
  end

  // Pops are taken one cycle late to keep instr_ready_i off this path
  assign icnt_n = kill_i ? '0 : icnt_adj + icnt_t'(n_incoming);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
      flush_q <= '0;
      icnt_q  <= '0;
      phase_q <= PHASE_ALIGNED;
      pop_q   <= 1'b0;
    end else begin
      outst_q <= outst_n;
      flush_q <= flush_n;
      icnt_q  <= icnt_n;
      phase_q <= phase_n;
      pop_q   <= emit_i;
    end
  end

endmodule

// ==== source/resp_fifo.sv ====
`timescale 1ns/1ns

module resp_fifo import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  logic  resp_accept_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  word_window_if.fifo_mp win
);

  word_t                 mem_q [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] err_q;
  logic [FIFO_DEPTH-1:0] valid_q, valid_n;
  ptr_t                  wptr, rptr, rptr2;

  // Step a pointer, wrapping after the last entry
  function automatic ptr_t ptr_next(input ptr_t p);
    ptr_t r;
    r = (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    return r;
  endfunction

  assign rptr2 = ptr_next(rptr);

  //////////////////////////////////////////////////
  // Read window
  //////////////////////////////////////////////////

  // Empty head entry is filled straight from the bus
  assign win.head_word  = valid_q[rptr] ? mem_q[rptr] : resp_rdata_i;
  assign win.head_err   = valid_q[rptr] ? err_q[rptr] : resp_err_i;
  assign win.head_valid = valid_q[rptr] || resp_accept_i;

  // Same for the second entry
  assign win.next_word  = valid_q[rptr2] ? mem_q[rptr2] : resp_rdata_i;
  assign win.next_err   = valid_q[rptr2] ? err_q[rptr2] : resp_err_i;
  // Stored entries fill in order, so a stored next implies a stored head
  assign win.next_valid = valid_q[rptr2] || (valid_q[rptr] && resp_accept_i);

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  // Set on write before clear on advance, covers the bypassed head
  always_comb begin
    valid_n = valid_q;
    if (resp_accept_i) begin
      valid_n[wptr] = 1'b1;
    end
    if (win.advance) begin
      valid_n[rptr] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr    <= '0;
      rptr    <= '0;
    end else begin
      // Kill drops every stored word
      valid_q <= kill_i ? '0 : valid_n;
      if (pc_set_i) begin
        wptr <= '0;
        rptr <= '0;
      end else begin
        if (resp_accept_i) begin
          wptr <= ptr_next(wptr);
        end
        if (win.advance) begin
          rptr <= rptr2;
        end
      end
    end
  end

  // Word store
  always_ff @(posedge clk) begin
    if (resp_accept_i) begin
      mem_q[wptr] <= resp_rdata_i;
      err_q[wptr] <= resp_err_i;
    end
  end

endmodule

// ==== source/instr_aligner.sv ====
`timescale 1ns/1ns

module instr_aligner import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  addr_t branch_addr_i,
  input  logic  instr_ready_i,
  word_window_if.aligner_mp win,
  output logic  emit_o,
  output logic  instr_valid_o,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o
);

  addr_t addr_q, addr_n;
  half_t head_hi, next_lo;
  logic  unaligned;
  logic  is_compressed;
  logic  aligned_is_compressed;
  logic  unaligned_is_compressed;
  logic  err_unaligned;

  //////////////////////////////////////////////////
  // Instruction assembly
  //////////////////////////////////////////////////

  assign unaligned = addr_q[1];
  assign head_hi   = win.head_word[31:16];
  assign next_lo   = win.next_word[15:0];

  // Only meaningful while the head is valid
  assign aligned_is_compressed   = win.head_word[1:0] != 2'b11;
  assign unaligned_is_compressed = head_hi[1:0] != 2'b11;
  assign is_compressed = unaligned ? unaligned_is_compressed : aligned_is_compressed;

  // Split instruction takes the fault of both words
  assign err_unaligned = unaligned_is_compressed ? win.head_err :
                         (win.head_err || win.next_err);

  always_comb begin
    if (unaligned) begin
      instr_rdata_o = {next_lo, head_hi};
      instr_err_o   = err_unaligned;
    end else begin
      instr_rdata_o = win.head_word;
      instr_err_o   = win.head_err;
    end
  end

  // Second word needed only by an unaligned 32-bit instruction
  always_comb begin
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end else if (unaligned && !unaligned_is_compressed) begin
      instr_valid_o = win.next_valid;
    end else begin
      instr_valid_o = win.head_valid;
    end
  end

  assign emit_o = instr_valid_o && instr_ready_i;

  // Head is kept only when its upper half still holds an instruction
  assign win.advance = emit_o && (unaligned || !aligned_is_compressed);

  //////////////////////////////////////////////////
  // Instruction address
  //////////////////////////////////////////////////

  always_comb begin
    addr_n = addr_q;
    if (pc_set_i) begin
      addr_n = branch_addr_i;
    end else if (emit_o) begin
      addr_n = addr_q + (is_compressed ? addr_t'(2) : addr_t'(4));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

// ==== source/alignment_buffer.sv ====
`timescale 1ns/1ns

module alignment_buffer import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Core control
  input  logic  instr_req_i,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  addr_t branch_addr_i,
  output logic  busy_o,
  // Prefetcher request side
  output logic  fetch_valid_o,
  input  logic  fetch_ready_i,
  output logic  fetch_branch_o,
  output addr_t fetch_branch_addr_o,
  // Prefetcher response side
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  // Fetch stage
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o
);

  logic resp_accept;
  logic emit;

  word_window_if win ();

  // Prefetcher restarts on the word holding the target
  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[31:2], 2'b00};

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_req_i   (instr_req_i),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i),
    .emit_i        (emit),
    .fetch_valid_o (fetch_valid_o),
    .busy_o        (busy_o),
    .resp_accept_o (resp_accept)
  );

  resp_fifo u_resp_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .win           (win.fifo_mp)
  );

  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .instr_ready_i (instr_ready_i),
    .win           (win.aligner_mp),
    .emit_o        (emit),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o)
  );

endmodule

// ==== sim/tb_alignment_buffer.sv ====
`timescale 1ns/1ns

module tb_alignment_buffer;

  //////////////////////////////////////////////////
  // Test sizing
  //////////////////////////////////////////////////

  localparam logic [31:0] SEED         = 32'h4eb8_7448;
  localparam int          HALVES       = 512;
  localparam int          WORDS        = HALVES / 2;
  localparam int          PHASES       = 3;
  localparam int          PHASE_INSTRS = 300;
  localparam int          PHASE_CYCLES = 4000;

  logic clk = 1'b0;
  logic rst_n = 1'b0;

  // DUT inputs
  logic        instr_req_i, pc_set_i, kill_i, fetch_ready_i;
  logic        resp_valid_i, resp_err_i, instr_ready_i;
  logic [31:0] branch_addr_i, resp_rdata_i;

  // DUT outputs
  logic        fetch_valid_o, fetch_branch_o, busy_o;
  logic        instr_valid_o, instr_err_o;
  logic [31:0] fetch_branch_addr_o, instr_rdata_o, instr_addr_o;

  // Program image with one fault flag per word
  logic [15:0] half_mem [HALVES];
  logic        word_err [WORDS];
  logic [31:0] lfsr;

  // Prefetcher model
  logic [31:0] fetch_addr;
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          cycle;
  int          in_flight;

  // Reference walker
  logic [31:0] exp_addr, exp_hi_addr;
  logic [15:0] exp_lo, exp_hi;
  logic        exp_c, exp_err, emit;
  int          checked_cnt, branch_cnt;

  always #50 clk = ~clk;

  alignment_buffer DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .pc_set_i            (pc_set_i),
    .kill_i              (kill_i),
    .branch_addr_i       (branch_addr_i),
    .busy_o              (busy_o),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_err_i          (resp_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_rdata_o       (instr_rdata_o),
    .instr_err_o         (instr_err_o),
    .instr_addr_o        (instr_addr_o)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] r;
    r = s >> 1;
    if (s[0]) begin
      r = r ^ 32'h8020_0003;
    end
    return r;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // Random mix of 16-bit and 32-bit instructions with about one faulty word in 8
  task automatic build_program();
    int          h;
    logic [15:0] lo;
    h = 0;
    while (h < HALVES) begin
      if ((h < HALVES - 1) && (rand_bits(1) == 32'd1)) begin
        lo = {14'(rand_bits(14)), 2'b11};
        half_mem[9'(h)]     = lo;
        half_mem[9'(h + 1)] = 16'(rand_bits(16));
        h = h + 2;
      end else begin
        lo = 16'(rand_bits(16));
        // Compressed opcodes never end in 11
        if (lo[1:0] == 2'b11) begin
          lo[1:0] = 2'b10;
        end
        half_mem[9'(h)] = lo;
        h = h + 1;
      end
    end
    for (int w = 0; w < WORDS; w++) begin
      word_err[8'(w)] = (rand_bits(3) == 32'd0);
    end
  endtask

  // Inputs for one cycle on the falling edge
  task automatic drive_cycle(input logic stall, input logic jump);
    logic [31:0] a;
    fetch_ready_i = (rand_bits(2) != 32'd0);
    // In-order responses once their delay is over
    if ((pend_addr.size() != 0) && (cycle >= pend_due[0])) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      resp_valid_i = 1'b1;
      resp_rdata_i = {half_mem[{a[9:2], 1'b1}], half_mem[{a[9:2], 1'b0}]};
      resp_err_i   = word_err[a[9:2]];
    end else begin
      resp_valid_i = 1'b0;
    end
    instr_ready_i = stall ? (rand_bits(1) == 32'd1) : 1'b1;
    pc_set_i      = 1'b0;
    kill_i        = 1'b0;
    // Branch always flushes and the target may be halfword aligned
    if (jump && (rand_bits(4) == 32'd0)) begin
      pc_set_i      = 1'b1;
      kill_i        = 1'b1;
      branch_addr_i = {22'd0, 9'(rand_bits(9)), 1'b0};
    end
  endtask

  task automatic run_phase(input logic stall, input logic jump);
    int start;
    start = checked_cnt;
    while (checked_cnt - start < PHASE_INSTRS) begin
      @(negedge clk);
      drive_cycle(stall, jump);
    end
  endtask

  //////////////////////////////////////////////////
  // Prefetcher and reference models
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin : prefetch_model
    logic [31:0] next_addr;
    int          delay;
    if (!rst_n) begin
      fetch_addr <= '0;
      in_flight  <= 0;
      cycle      <= 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      // Restart at the target word on a branch
      next_addr = fetch_branch_o ? fetch_branch_addr_o : fetch_addr;
      if (fetch_valid_o && fetch_ready_i) begin
        delay = int'(rand_bits(2));
        if (delay == 0) begin
          delay = 1;
        end
        pend_addr.push_back(next_addr);
        pend_due.push_back(cycle + delay);
        next_addr = next_addr + 32'd4;
      end
      fetch_addr <= next_addr;
      in_flight  <= in_flight + ((fetch_valid_o && fetch_ready_i) ? 1 : 0) -
                    (resp_valid_i ? 1 : 0);
      cycle      <= cycle + 1;
    end
  end

  // Expected instruction at the walker address
  assign exp_hi_addr = exp_addr + 32'd2;
  assign exp_lo      = half_mem[exp_addr[9:1]];
  assign exp_hi      = half_mem[exp_hi_addr[9:1]];
  assign exp_c       = exp_lo[1:0] != 2'b11;
  assign exp_err     = exp_c ? word_err[exp_addr[9:2]] :
                       (word_err[exp_addr[9:2]] | word_err[exp_hi_addr[9:2]]);
  assign emit        = instr_valid_o && instr_ready_i;

  always @(posedge clk or negedge rst_n) begin : ref_walker
    if (!rst_n) begin
      exp_addr    <= '0;
      checked_cnt <= 0;
      branch_cnt  <= 0;
    end else if (pc_set_i) begin
      exp_addr   <= branch_addr_i;
      branch_cnt <= branch_cnt + 1;
    end else if (emit) begin
      exp_addr    <= exp_addr + (exp_c ? 32'd2 : 32'd4);
      checked_cnt <= checked_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Also covers the first instruction after a branch
  chk_addr: assert property (@(posedge clk) disable iff (!rst_n)
    emit |-> (instr_addr_o == exp_addr))
    else report_mismatch("instruction address differs from the reference");

  chk_data: assert property (@(posedge clk) disable iff (!rst_n)
    emit |-> (exp_c ? (instr_rdata_o[15:0] == exp_lo) : (instr_rdata_o == {exp_hi, exp_lo})))
    else report_mismatch("instruction data differs from the reference");

  chk_err: assert property (@(posedge clk) disable iff (!rst_n)
    emit |-> (instr_err_o == exp_err))
    else report_mismatch("bus error flag differs from the reference");

  // Prefetcher restarts on the word that holds the target
  chk_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_branch_o == pc_set_i) &&
    (!pc_set_i || (fetch_branch_addr_o == (branch_addr_i & ~32'd3))))
    else report_mismatch("fetch branch outputs differ from the branch request");

  chk_outst: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= 2)
    else report_mismatch("more than two fetches outstanding");

  chk_busy: assert property (@(posedge clk) disable iff (!rst_n)
    ((in_flight != 0) || fetch_valid_o) |-> busy_o)
    else report_mismatch("busy_o low with fetch activity");

  chk_req: assert property (@(posedge clk) disable iff (!rst_n)
    !instr_req_i |-> !fetch_valid_o)
    else report_mismatch("fetch_valid_o high without instr_req_i");

  chk_kill: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !instr_valid_o)
    else report_mismatch("instr_valid_o high during kill");

  // Upper half only matters for a 32-bit instruction
  chk_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !pc_set_i && !kill_i) |=>
    (pc_set_i || kill_i ||
     (instr_valid_o && $stable(instr_addr_o) && $stable(instr_err_o) &&
      $stable(instr_rdata_o[15:0]) &&
      ((instr_rdata_o[1:0] != 2'b11) || $stable(instr_rdata_o[31:16])))))
    else report_mismatch("outputs changed under back-pressure");

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial begin : watchdog
    repeat (PHASES * PHASE_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", PHASES * PHASE_CYCLES);
    abort_run();
  end

  initial begin : main
    lfsr          = SEED;
    instr_req_i   = 1'b0;
    pc_set_i      = 1'b0;
    kill_i        = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    resp_err_i    = 1'b0;
    instr_ready_i = 1'b0;
    build_program();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Idle with no request right after reset
    @(negedge clk);
    chk_idle: assert (!instr_valid_o && !busy_o)
      else report_mismatch("instr_valid_o or busy_o high after reset");
    @(negedge clk);
    instr_req_i = 1'b1;
    // Plain stream, then back-pressure, then branches on top
    run_phase(1'b0, 1'b0);
    run_phase(1'b1, 1'b0);
    run_phase(1'b1, 1'b1);
    if (branch_cnt > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("No branch was applied during the branch phase");
      abort_run();
    end
  end

endmodule

// ==== filelist.f ====
source/align_pkg.sv
source/word_window_if.sv
source/fetch_ctrl.sv
source/resp_fifo.sv
source/instr_aligner.sv
source/alignment_buffer.sv
sim/tb_alignment_buffer.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_alignment_buffer -f filelist.f \
		-o tb_alignment_buffer
	./obj_dir/tb_alignment_buffer

clean:
	rm -rf obj_dir
